// ==== hdl/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define WORD_W 32
`define REG_AW 5
`define RAM_AW 8  // Data RAM word address bits

// Immediate forms of the major opcodes have bit 3 set
`define OPC_ADD  6'o00
`define OPC_ADDI 6'o10
`define OPC_BSF  6'o21
`define OPC_BSFI 6'o31
`define OPC_OR   6'o40
`define OPC_AND  6'o41
`define OPC_XOR  6'o42
`define OPC_SRX  6'o44
`define OPC_LW   6'o62
`define OPC_SW   6'o66
`define OPC_LWI  6'o72
`define OPC_SWI  6'o76

`endif

// ==== hdl/isaPkg.sv ====
`include "core_defs.svh"

package isaPkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`REG_AW-1:0] regIdx_t;
  typedef logic [5:0]         opcode_t;
  typedef logic [15:0]        imm_t;  // Low half of the instruction word

  // Field order matches the instruction word with the opcode on top
  typedef struct packed {
    opcode_t     opc;
    regIdx_t     rd;
    regIdx_t     ra;
    regIdx_t     rb;
    logic [10:0] alt;  // Function bits or the low part of the immediate
  } instr_t;

endpackage

// ==== hdl/pipePkg.sv ====
package pipePkg;

  // Operand source in X
  typedef enum logic [1:0] {
    srcReg,  // Register file or the late path
    srcFwd,  // ALU result now in R
    srcRam,  // Load data now in R
    srcImm
  } srcSel_t;

  // What the R stage writes back
  typedef enum logic [1:0] {
    dstAlu,
    dstMem,
    dstNone
  } dstSel_t;

  typedef enum logic [1:0] {
    aluAdd,
    aluLogic,
    aluShift,   // Single bit right
    aluBarrel   // Two cycles in X
  } aluFn_t;

  typedef struct packed {
    aluFn_t          aluFn;
    logic [1:0]      logicOp;    // 00 or, 01 and, 10 xor
    logic            shiftLeft;  // Barrel direction
    srcSel_t         srcA;
    srcSel_t         srcB;
    srcSel_t         srcSt;      // Store data from the B port
    dstSel_t         dst;
    isaPkg::regIdx_t rd;
    logic            we;         // Never set for r0
    logic            load;
    logic            store;
    isaPkg::imm_t    imm;
  } xCtrl_t;

  typedef struct packed {
    logic            valid;
    isaPkg::regIdx_t rd;
    isaPkg::word_t   data;
  } wb_t;

endpackage

// ==== hdl/pipeCtrl.sv ====
`include "core_defs.svh"

module pipeCtrl (
  input  logic            gclk,
  input  logic            rstN,
  input  isaPkg::instr_t  instr,
  input  logic            instrValid,
  output logic            instrReady,
  output isaPkg::regIdx_t raIdx,
  output isaPkg::regIdx_t rbIdx,
  output pipePkg::xCtrl_t xCtrl,
  output logic            lateA,
  output logic            lateB
);

  isaPkg::opcode_t opcBase;
  logic            isAdd;
  logic            isLog;
  logic            isSrx;
  logic            isBsf;
  logic            isLoad;
  logic            isStore;
  logic            useImm;
  logic            writes;
  logic            accept;
  logic            stallQ;  // Barrel shift in its first X cycle
  logic            rWe;
  isaPkg::regIdx_t rRd;
  pipePkg::xCtrl_t dCtrl;

  // Source select against the instruction now in X
  function automatic pipePkg::srcSel_t fwdSel(isaPkg::regIdx_t idx, pipePkg::xCtrl_t x);
    if (x.we && (x.rd == idx))
      return (x.dst == pipePkg::dstMem) ? pipePkg::srcRam : pipePkg::srcFwd;
    return pipePkg::srcReg;
  endfunction

  assign opcBase = instr.opc & 6'b110111;  // Fold immediate forms
  assign isAdd   = (instr.opc == `OPC_ADD) || (instr.opc == `OPC_ADDI);
  assign isLog   = (opcBase == `OPC_AND) || (opcBase == `OPC_OR) || (opcBase == `OPC_XOR);
  assign isSrx   = (instr.opc == `OPC_SRX);
  assign isBsf   = (instr.opc == `OPC_BSF) || (instr.opc == `OPC_BSFI);
  assign isLoad  = (instr.opc == `OPC_LW) || (instr.opc == `OPC_LWI);
  assign isStore = (instr.opc == `OPC_SW) || (instr.opc == `OPC_SWI);
  assign useImm  = instr.opc[3];
  assign writes  = isAdd | isLog | isSrx | isBsf | isLoad;

  assign instrReady = !stallQ;
  assign accept     = instrValid && instrReady;

  // Stores read rd on the B port for their data
  assign raIdx = instr.ra;
  assign rbIdx = isStore ? instr.rd : instr.rb;

  // Write two ahead lands on the same edge as the operand capture
  assign lateA = rWe && (rRd == raIdx);
  assign lateB = rWe && (rRd == rbIdx);

  always_comb begin
    if (isBsf)
      dCtrl.aluFn = pipePkg::aluBarrel;
    else if (isSrx)
      dCtrl.aluFn = pipePkg::aluShift;
    else if (isLog)
      dCtrl.aluFn = pipePkg::aluLogic;
    else
      dCtrl.aluFn = pipePkg::aluAdd;  // Also the address sum for memory ops
    dCtrl.logicOp   = instr.opc[1:0];
    dCtrl.shiftLeft = instr.alt[10];
    dCtrl.srcA      = fwdSel(raIdx, xCtrl);
    dCtrl.srcB      = (useImm || isStore) ? pipePkg::srcImm : fwdSel(rbIdx, xCtrl);
    dCtrl.srcSt     = fwdSel(rbIdx, xCtrl);
    if (isLoad)
      dCtrl.dst = pipePkg::dstMem;
    else if (writes)
      dCtrl.dst = pipePkg::dstAlu;
    else
      dCtrl.dst = pipePkg::dstNone;
    dCtrl.rd    = instr.rd;
    dCtrl.we    = writes && (instr.rd != '0);
    dCtrl.load  = isLoad;
    dCtrl.store = isStore;
    // Register-form store addresses by ra alone
    dCtrl.imm   = (isStore && !useImm) ? '0 : {instr.rb, instr.alt};
  end

  always_ff @(posedge gclk) begin
    if (!rstN) begin
      xCtrl  <= '0;
      stallQ <= 1'b0;
      rWe    <= 1'b0;
    end else begin
      stallQ <= accept && isBsf;
      rWe    <= xCtrl.we && !stallQ;  // First barrel cycle sends a bubble to R
      if (!stallQ) begin
        if (accept)
          xCtrl <= dCtrl;
        else
          xCtrl <= '0;  // Bubble
      end
    end
  end

  always_ff @(posedge gclk) begin
    rRd <= xCtrl.rd;
  end

endmodule

// ==== hdl/regFile.sv ====
`include "core_defs.svh"

module regFile (
  input  logic            gclk,
  input  logic            rstN,
  input  isaPkg::regIdx_t raIdx,
  input  isaPkg::regIdx_t rbIdx,
  input  pipePkg::wb_t    wr,
  output isaPkg::word_t   rdA,
  output isaPkg::word_t   rdB
);

  // r0 has no storage
  isaPkg::word_t regs [1:(1 << `REG_AW) - 1];

  always_ff @(posedge gclk) begin
    if (rstN && wr.valid && (wr.rd != '0))
      regs[wr.rd] <= wr.data;
  end

  assign rdA = (raIdx == '0) ? '0 : regs[raIdx];
  assign rdB = (rbIdx == '0) ? '0 : regs[rbIdx];

endmodule

// ==== hdl/execUnit.sv ====
module execUnit (
  input  logic            gclk,
  input  logic            rstN,
  input  pipePkg::xCtrl_t xCtrl,
  input  isaPkg::word_t   rdA,
  input  isaPkg::word_t   rdB,
  input  logic            lateA,
  input  logic            lateB,
  input  isaPkg::word_t   ramData,
  output isaPkg::word_t   memAddr,
  output isaPkg::word_t   memWrData,
  output pipePkg::wb_t    wb
);

  isaPkg::word_t   opA;  // Captured as the instruction enters X
  isaPkg::word_t   opB;
  isaPkg::word_t   immExt;
  isaPkg::word_t   srcA;
  isaPkg::word_t   srcB;
  isaPkg::word_t   sum;
  isaPkg::word_t   logicRes;
  isaPkg::word_t   shiftRes;
  isaPkg::word_t   bsfIn;
  isaPkg::word_t   bsfPart;
  isaPkg::word_t   bsfOut;
  isaPkg::word_t   aluRes;
  isaPkg::word_t   aluR;
  logic [1:0]      bsfFine;  // Low shift bits kept for the second cycle
  logic            bsfPhase;
  logic            shiftFill;
  logic            rValid;
  logic            rLoad;
  isaPkg::regIdx_t rRd;

  function automatic isaPkg::word_t pickSrc(pipePkg::srcSel_t sel, isaPkg::word_t regVal,
                                            isaPkg::word_t fwdVal, isaPkg::word_t ramVal,
                                            isaPkg::word_t immVal);
    case (sel)
      pipePkg::srcFwd: return fwdVal;
      pipePkg::srcRam: return ramVal;
      pipePkg::srcImm: return immVal;
      default:         return regVal;
    endcase
  endfunction

  function automatic isaPkg::word_t shiftBy(isaPkg::word_t val, logic [4:0] amt,
                                            logic left, logic arith);
    if (left)
      return val << amt;
    if (arith)
      return $signed(val) >>> amt;
    return val >> amt;
  endfunction

  // Late path takes the value being written this edge
  always_ff @(posedge gclk) begin
    opA <= lateA ? wb.data : rdA;
    opB <= lateB ? wb.data : rdB;
  end

  assign immExt    = {{16{xCtrl.imm[15]}}, xCtrl.imm};
  assign srcA      = pickSrc(xCtrl.srcA, opA, aluR, ramData, immExt);
  assign srcB      = pickSrc(xCtrl.srcB, opB, aluR, ramData, immExt);
  assign sum       = srcA + srcB;
  assign memAddr   = sum;
  assign memWrData = pickSrc(xCtrl.srcSt, opB, aluR, ramData, immExt);

  always_comb begin
    case (xCtrl.logicOp)
      2'b00:   logicRes = srcA | srcB;
      2'b01:   logicRes = srcA & srcB;
      default: logicRes = srcA ^ srcB;
    endcase
  end

  assign shiftFill = (xCtrl.imm[6:5] == 2'b00) ? srcA[31] : 1'b0;  // sra keeps sign
  assign shiftRes  = {shiftFill, srcA[31:1]};

  // Multiples of four in the first cycle and the remainder in the second
  assign bsfIn  = shiftBy(srcA, {srcB[4:2], 2'b00}, xCtrl.shiftLeft, xCtrl.imm[9]);
  assign bsfOut = shiftBy(bsfPart, {3'b000, bsfFine}, xCtrl.shiftLeft, xCtrl.imm[9]);

  always_comb begin
    case (xCtrl.aluFn)
      pipePkg::aluLogic:  aluRes = logicRes;
      pipePkg::aluShift:  aluRes = shiftRes;
      pipePkg::aluBarrel: aluRes = bsfOut;
      default:            aluRes = sum;
    endcase
  end

  always_ff @(posedge gclk) begin
    bsfPart <= bsfIn;
    bsfFine <= srcB[1:0];
    aluR    <= aluRes;
    rRd     <= xCtrl.rd;
    rLoad   <= xCtrl.load;
  end

  always_ff @(posedge gclk) begin
    if (!rstN) begin
      bsfPhase <= 1'b0;
      rValid   <= 1'b0;
    end else begin
      bsfPhase <= (xCtrl.aluFn == pipePkg::aluBarrel) && !bsfPhase;
      // Barrel result only after its second cycle
      rValid   <= xCtrl.we && !((xCtrl.aluFn == pipePkg::aluBarrel) && !bsfPhase);
    end
  end

  always_comb begin
    wb.valid = rValid;
    wb.rd    = rRd;
    wb.data  = rLoad ? ramData : aluR;
  end

endmodule

// ==== hdl/dataRam.sv ====
`include "core_defs.svh"

module dataRam (
  input  logic            gclk,
  input  pipePkg::xCtrl_t xCtrl,
  input  isaPkg::word_t   memAddr,
  input  isaPkg::word_t   memWrData,
  output isaPkg::word_t   rdData
);

  isaPkg::word_t           mem [0:(1 << `RAM_AW) - 1];
  logic [`RAM_AW-1:0]      wordAddr;

  assign wordAddr = memAddr[`RAM_AW+1:2];  // Byte address to word index

  always_ff @(posedge gclk) begin
    if (xCtrl.store)
      mem[wordAddr] <= memWrData;
    rdData <= mem[wordAddr];  // Old data on a same-address store
  end

endmodule

// ==== hdl/coreTop.sv ====
module coreTop (
  input  logic          gclk,
  input  logic          rstN,
  input  isaPkg::word_t instr,
  input  logic          instrValid,
  output logic          instrReady,
  output pipePkg::wb_t  wb
);

  pipePkg::xCtrl_t xCtrl;
  isaPkg::regIdx_t raIdx;
  isaPkg::regIdx_t rbIdx;
  isaPkg::word_t   rdA;
  isaPkg::word_t   rdB;
  isaPkg::word_t   memAddr;
  isaPkg::word_t   memWrData;
  isaPkg::word_t   rdData;
  logic            lateA;
  logic            lateB;

  pipeCtrl u_ctrl (
    .gclk       (gclk),
    .rstN       (rstN),
    .instr      (instr),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .raIdx      (raIdx),
    .rbIdx      (rbIdx),
    .xCtrl      (xCtrl),
    .lateA      (lateA),
    .lateB      (lateB)
  );

  regFile u_regFile (
    .gclk  (gclk),
    .rstN  (rstN),
    .raIdx (raIdx),
    .rbIdx (rbIdx),
    .wr    (wb),     // R stage result is the write port
    .rdA   (rdA),
    .rdB   (rdB)
  );

  execUnit u_exec (
    .gclk      (gclk),
    .rstN      (rstN),
    .xCtrl     (xCtrl),
    .rdA       (rdA),
    .rdB       (rdB),
    .lateA     (lateA),
    .lateB     (lateB),
    .ramData   (rdData),
    .memAddr   (memAddr),
    .memWrData (memWrData),
    .wb        (wb)
  );

  dataRam u_ram (
    .gclk      (gclk),
    .xCtrl     (xCtrl),
    .memAddr   (memAddr),
    .memWrData (memWrData),
    .rdData    (rdData)
  );

endmodule

// ==== testbench/coreTb.sv ====
`include "core_defs.svh"

module coreTb;

  logic          gclk;
  logic          rstN;
  isaPkg::word_t instr;
  logic          instrValid;
  logic          instrReady;
  pipePkg::wb_t  wb;

  int            seed = 38;
  int            errors;
  int            testErrors;
  int            checks;
  int            cycleCount;
  int            cycleLimit;
  logic          barrelPending;  // Barrel shift taken on the last rising edge
  int            traceTest [$];
  isaPkg::word_t traceInstr [$];
  int            traceRd [$];
  isaPkg::word_t traceData [$];
  pipePkg::wb_t  expected [$];  // Writebacks still to come in program order
  int            expDue [$];    // Cycle count at which each one should show

  coreTop u_dut (
    .gclk       (gclk),
    .rstN       (rstN),
    .instr      (instr),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .wb         (wb)
  );

  initial begin
    gclk = 1'b0;
    forever #2 gclk = ~gclk;
  end

  always @(posedge gclk) cycleCount <= cycleCount + 1;

  function automatic string testName(input int num);
    case (num)
      1:       return "reset state";
      2:       return "ALU results";
      3:       return "forwarding";
      4:       return "memory";
      5:       return "barrel shift";
      6:       return "register 0";
      default: return "unnamed";
    endcase
  endfunction

  task automatic countError();
    errors++;
    testErrors++;
  endtask

  // Outputs settle after the rising edge, so look at them on the falling one
  always @(negedge gclk) begin : checkWriteback
    pipePkg::wb_t exp;
    int           due;
    if (wb.valid !== 1'b0) begin
      assert (expected.size() != 0) else begin
        $display("Writeback to r%0d at time %0t with no instruction expecting one", wb.rd, $time);
        countError();
      end
      if (expected.size() != 0) begin
        exp = expected.pop_front();
        due = expDue.pop_front();
        checks++;
        assert (wb.rd === exp.rd && wb.data === exp.data) else begin
          $display("[FAIL] %0t: expected r%0d = %h, got r%0d = %h",
                   $time, exp.rd, exp.data, wb.rd, wb.data);
          countError();
        end
        assert (cycleCount == due) else begin
          $display("[FAIL] %0t: writeback to r%0d at cycle %0d, expected at cycle %0d",
                   $time, wb.rd, cycleCount, due);
          countError();
        end
      end
    end
  end

  task automatic nextCycle();
    @(negedge gclk);
    assert (instrReady === !barrelPending) else begin
      $display("[FAIL] %0t: instrReady is %b, expected %b", $time, instrReady, !barrelPending);
      countError();
    end
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      nextCycle();
      instrValid    = 1'b0;
      barrelPending = 1'b0;
    end
  endtask

  // Held on the port until the DUT is ready for it
  task automatic sendInstr(input isaPkg::word_t w);
    nextCycle();
    instr      = w;
    instrValid = 1'b1;
    while (instrReady !== 1'b1) begin
      barrelPending = 1'b0;
      nextCycle();
    end
    barrelPending = (w[31:26] == `OPC_BSF) || (w[31:26] == `OPC_BSFI);
  endtask

  task automatic finishTest(input int num);
    while (expected.size() != 0)
      idleCycles(1);
    $display("Test %0d (%s) done with %0d errors", num, testName(num), testErrors);
    testErrors = 0;
    idleCycles($unsigned($random(seed)) % 4);  // Gap before the next group
  endtask

  task automatic loadTrace(input int fd);
    logic [8*96-1:0] line;
    int              num;
    int              rd;
    isaPkg::word_t   w;
    isaPkg::word_t   d;
    while (!$feof(fd)) begin
      line = '0;
      if ($fgets(line, fd) != 0 && $sscanf(line, "%d %h %d %h", num, w, rd, d) == 4) begin
        traceTest.push_back(num);
        traceInstr.push_back(w);
        traceRd.push_back(rd);
        traceData.push_back(d);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int           fd;
    pipePkg::wb_t entry;
    rstN          = 1'b0;
    instr         = '0;
    instrValid    = 1'b0;
    barrelPending = 1'b0;
    fd = $fopen("testbench/core_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/core_trace.txt, so there is no stimulus to run");
      $display("TEST FAIL");
      $finish;
    end else begin
      loadTrace(fd);
      cycleLimit = traceTest.size() * 8 + 200;
      repeat (10) nextCycle();
      rstN = 1'b1;
      idleCycles(3);
      finishTest(1);
      for (int i = 0; i < traceTest.size(); i++) begin
        if (i > 0 && traceTest[i] != traceTest[i-1])
          finishTest(traceTest[i-1]);
        sendInstr(traceInstr[i]);
        // Taken on the next rising edge, result two edges later, barrel one more
        if (traceRd[i] != 0) begin
          entry.valid = 1'b1;
          entry.rd    = traceRd[i];
          entry.data  = traceData[i];
          expected.push_back(entry);
          expDue.push_back(cycleCount + (barrelPending ? 3 : 2));
        end
      end
      finishTest(traceTest[traceTest.size()-1]);
      $display("Writebacks checked: %0d, errors: %0d", checks, errors);
      if (errors == 0)
        $display("TEST PASS");
      else
        $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    wait (cycleLimit != 0);
    wait (cycleCount >= cycleLimit);
    $display("Timeout after %0d cycles, the pipeline stopped making progress", cycleCount);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/pipeCtrl.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/dataRam.sv
hdl/coreTop.sv
testbench/coreTb.sv

// ==== testbench/core_trace.txt ====
# test  instr     rd  data      (instr and data in hex, test and rd in decimal)
# rd 0 means no writeback is expected, as for stores and writes to r0
2 20201234 1  00001234
2 2040FFF0 2  FFFFFFF0
2 00611000 3  00001224
2 84A11000 5  00001230
2 A0E100F0 7  000012F4
2 A9218000 9  FFFF9234
2 91420001 10 FFFFFFF8
2 91620041 11 7FFFFFF8
3 21800005 12 00000005
3 01AC6000 13 0000000A
3 01CD6000 14 0000000F
3 898E0800 12 0000123B
4 20200040 1  00000040
4 20405A5A 2  00005A5A
4 F8410004 0  00000000
4 E8610004 3  00005A5A
4 00831000 4  0000B4B4
5 21000007 8  00000007
5 45224400 9  002D2D00
5 01494000 10 002D2D07
5 2180FF00 12 FFFFFF00
5 65AC0205 13 FFFFFFF8
6 20000077 0  00000000
6 00200000 1  00000000
6 A004FFFF 0  00000000
6 00402000 2  0000B4B4
